//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = fetch_unit_tb
FILELIST  = fetch_unit.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- fetch_unit.f
hw/fetch_pkg.sv
hw/byte_window_cache.sv
hw/word_ram.sv
hw/operand_extract.sv
hw/fetch_unit.sv
verification/fetch_checks.sv
verification/fetch_unit_tb.sv

//--- hw/byte_window_cache.sv
`default_nettype none

module byte_window_cache (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cen,
    input  fetch_pkg::fetch_req_t               req,
    output logic [fetch_pkg::addr_bits-1:0]     ram_addr,
    input  logic [fetch_pkg::word_bits-1:0]     ram_dout,
    output logic [fetch_pkg::window_bits-1:0]   window,
    output logic                                rdy
);
    import fetch_pkg::*;

    // window state.
    logic [window_bytes-1:0][7:0] win_q;
    logic [addr_bits-1:0]         base_addr;
    logic [window_bytes-1:0]      valid;
    logic [window_bytes-1:0]      pending;

    // request decode.
    logic [addr_bits-1:0]         req_addr;
    logic [addr_bits-1:0]         delta;
    logic                         filling;
    logic                         miss;
    logic                         reuse1;
    logic                         reuse2;
    logic                         reuse3;

    // per-byte fill steering.
    logic [window_bytes-1:0]      lane_hit;
    logic [window_bytes-1:0][7:0] lane_byte;

    // data loads take the indexed address.
    assign req_addr = req.ldram_en ? req.idx_addr : req.pc;
    assign delta    = req_addr - base_addr;

    // ready needs a full window at the right base.
    assign rdy     = &valid && (base_addr == req_addr);
    assign filling = |pending;
    // a new request is only looked at once the fill is done.
    assign miss    = !filling && !rdy;

    // forward steps that keep some of the old bytes.
    assign reuse1 = miss && (delta == addr_bits'(1)) && (&valid[3:1]);
    assign reuse2 = miss && (delta == addr_bits'(2)) && (&valid[3:2]);
    assign reuse3 = miss && (delta == addr_bits'(3)) && valid[3];

    assign window = win_q;

    // a pending byte fills when its word is on the bus.
    always_comb begin
        logic [addr_bits-1:0] byte_addr;
        for (int k = 0; k < window_bytes; k++) begin
            byte_addr    = base_addr + addr_bits'(k);
            lane_hit[k]  = pending[k] &&
                           (byte_addr[addr_bits-1:1] == ram_addr[addr_bits-1:1]);
            // odd bytes sit in the upper lane.
            lane_byte[k] = byte_addr[0] ? ram_dout[15:8] : ram_dout[7:0];
        end
    end

    // control state.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_addr  <= '0;
            base_addr <= '0;
            valid     <= '0;
            pending   <= '0;
        end else if (cen) begin
            if (filling) begin
                // zero wait states, one word per cycle.
                ram_addr <= ram_addr + addr_bits'(2);
                valid    <= valid | lane_hit;
                pending  <= pending & ~lane_hit;
            end else if (miss) begin
                base_addr <= req_addr;
                if (reuse1) begin
                    // only the top byte is new.
                    ram_addr <= req_addr + addr_bits'(3);
                    valid    <= 4'b0111;
                    pending  <= 4'b1000;
                end else if (reuse2) begin
                    ram_addr <= req_addr + addr_bits'(2);
                    valid    <= 4'b0011;
                    pending  <= 4'b1100;
                end else if (reuse3) begin
                    ram_addr <= req_addr + addr_bits'(1);
                    valid    <= 4'b0001;
                    pending  <= 4'b1110;
                end else begin
                    // far jump, reload everything.
                    ram_addr <= req_addr;
                    valid    <= '0;
                    pending  <= '1;
                end
            end
        end
    end

    // window bytes.
    always_ff @(posedge clk) begin
        if (cen) begin
            if (filling) begin
                for (int k = 0; k < window_bytes; k++) begin
                    if (lane_hit[k]) begin
                        win_q[k] <= lane_byte[k];
                    end
                end
            end else if (reuse1) begin
                win_q <= {8'h00, win_q[3:1]};
            end else if (reuse2) begin
                win_q <= {16'h0000, win_q[3:2]};
            end else if (reuse3) begin
                // kept byte moves to lane 0.
                win_q <= {24'h000000, win_q[3]};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // byte address width of the core bus.
    localparam int addr_bits = 24;

    // memory data bus width.
    localparam int word_bits = 16;

    // word index width, 2048 words of 16 bits.
    localparam int mem_word_bits = 11;
    localparam int mem_words = 1 << mem_word_bits;

    // the prefetch window holds four bytes.
    localparam int window_bytes = 4;
    localparam int window_bits = 8 * window_bytes;

    // operand width requested by the decoder.
    typedef enum logic [1:0] {
        op_byte = 2'd0,
        op_word = 2'd1,
        op_long = 2'd2
    } op_size_t;

    // what the core presents each cycle.
    typedef struct packed {
        logic [addr_bits-1:0] pc;
        logic [addr_bits-1:0] idx_addr;
        logic                 ldram_en;
    } fetch_req_t;

    // operand size and extension mode.
    typedef struct packed {
        op_size_t size;
        logic     sign;
    } operand_req_t;

    // preload write port into the word memory.
    typedef struct packed {
        logic                     we;
        logic [mem_word_bits-1:0] addr;
        logic [word_bits-1:0]     data;
    } preload_t;

endpackage

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  fetch_pkg::fetch_req_t             req,
    input  fetch_pkg::operand_req_t           opreq,
    input  fetch_pkg::preload_t               preload,
    output logic [fetch_pkg::window_bits-1:0] operand,
    output logic [fetch_pkg::window_bits-1:0] window,
    output logic                              rdy
);
    import fetch_pkg::*;

    // memory bus between cache and ram.
    logic [addr_bits-1:0] ram_addr;
    logic [word_bits-1:0] ram_dout;

    // prefetch window, refilled from the ram.
    byte_window_cache u_cache (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .req      (req),
        .ram_addr (ram_addr),
        .ram_dout (ram_dout),
        .window   (window),
        .rdy      (rdy)
    );

    // word memory.
    word_ram u_ram (
        .clk      (clk),
        .preload  (preload),
        .ram_addr (ram_addr),
        .ram_dout (ram_dout)
    );

    // operand from the window, valid with rdy.
    operand_extract u_extract (
        .window   (window),
        .opreq    (opreq),
        .operand  (operand)
    );

endmodule

`default_nettype wire

//--- hw/operand_extract.sv
`default_nettype none

module operand_extract (
    input  logic [fetch_pkg::window_bits-1:0] window,
    input  fetch_pkg::operand_req_t           opreq,
    output logic [fetch_pkg::window_bits-1:0] operand
);
    import fetch_pkg::*;

    // fill bits for the narrow sizes.
    logic byte_fill;
    logic word_fill;

    // top bit when signed, zero otherwise.
    assign byte_fill = opreq.sign & window[7];
    assign word_fill = opreq.sign & window[15];

    always_comb begin
        case (opreq.size)
            op_byte: begin
                operand = {{24{byte_fill}}, window[7:0]};
            end
            op_word: begin
                operand = {{16{word_fill}}, window[15:0]};
            end
            default: begin
                // long, whole window.
                operand = window;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/word_ram.sv
`default_nettype none

module word_ram (
    input  logic                            clk,
    input  fetch_pkg::preload_t             preload,
    input  logic [fetch_pkg::addr_bits-1:0] ram_addr,
    output logic [fetch_pkg::word_bits-1:0] ram_dout
);
    import fetch_pkg::*;

    // 2048 words, even byte in the low half.
    logic [word_bits-1:0] mem [mem_words];

    // word index from the byte address.
    logic [mem_word_bits-1:0] rd_idx;

    // byte addresses wrap at 4 KiB.
    assign rd_idx = ram_addr[mem_word_bits:1];

    // preload port, runs without cen.
    always_ff @(posedge clk) begin
        if (preload.we) begin
            mem[preload.addr] <= preload.data;
        end
    end

    // zero wait state read.
    assign ram_dout = mem[rd_idx];

endmodule

`default_nettype wire

//--- verification/fetch_checks.sv
`default_nettype none

module fetch_checks (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  fetch_pkg::fetch_req_t             req,
    input  fetch_pkg::operand_req_t           opreq,
    input  fetch_pkg::preload_t               preload,
    input  logic [fetch_pkg::window_bits-1:0] operand,
    input  logic [fetch_pkg::window_bits-1:0] window,
    input  logic                              rdy,
    output int                                errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // bytes in the 4 KiB image.
    localparam int image_bytes = 2 * mem_words;
    // looser than the worst refill.
    localparam int rdy_bound = 16;

    // reference byte image, filled from the preload port.
    logic [7:0] image [image_bytes];

    int err_count = 0;
    int wait_cnt;
    logic seen_cen;
    logic have_prev;
    logic prev_cen;
    logic prev_rdy;
    logic [window_bits-1:0] prev_window;
    fetch_req_t prev_req;

    assign errors = err_count;

    // even byte low, odd byte high.
    always @(posedge clk) begin
        if (preload.we) begin
            image[{preload.addr, 1'b0}] <= preload.data[7:0];
            image[{preload.addr, 1'b1}] <= preload.data[15:8];
        end
    end

    // data loads use the indexed address.
    function automatic logic [addr_bits-1:0] request_address(fetch_req_t r);
        if (r.ldram_en) begin
            return r.idx_addr;
        end
        return r.pc;
    endfunction

    // four bytes from the image, little-endian, wrapping at 4 KiB.
    function automatic logic [window_bits-1:0] image_window(logic [addr_bits-1:0] a);
        logic [window_bits-1:0] w;
        logic [11:0] idx;
        for (int k = 0; k < window_bytes; k++) begin
            idx = a[11:0] + 12'(k);
            w[8*k +: 8] = image[idx];
        end
        return w;
    endfunction

    // operand by size, sign or zero extended.
    function automatic logic [window_bits-1:0] expected_operand(
        logic [window_bits-1:0] w,
        operand_req_t           o
    );
        logic signed [7:0] sb;
        logic signed [15:0] sw;
        logic [window_bits-1:0] v;
        sb = w[7:0];
        sw = w[15:0];
        if (o.size == op_byte) begin
            if (o.sign) v = 32'(sb);
            else v = {24'h000000, w[7:0]};
        end else if (o.size == op_word) begin
            if (o.sign) v = 32'(sw);
            else v = {16'h0000, w[15:0]};
        end else begin
            v = w;
        end
        return v;
    endfunction

    always @(posedge clk) begin : checks
        logic [window_bits-1:0] exp_window;
        logic [window_bits-1:0] exp_operand;
        if (rst) begin
            seen_cen  = 1'b0;
            have_prev = 1'b0;
            wait_cnt  = 0;
        end else begin
            // nothing fetched yet.
            if (!seen_cen) begin
                assert (!rdy) else begin
                    err_count++;
                    $display("rdy went high at %0t before any cen cycle after reset", $time);
                end
            end
            // window and operand against the image.
            if (rdy) begin
                exp_window  = image_window(request_address(req));
                exp_operand = expected_operand(exp_window, opreq);
                assert (window == exp_window) else begin
                    err_count++;
                    $display("mismatch at %0t: window expected %h actual %h",
                             $time, exp_window, window);
                end
                assert (operand == exp_operand) else begin
                    err_count++;
                    $display("mismatch at %0t: operand expected %h actual %h",
                             $time, exp_operand, operand);
                end
            end
            // a cen-low edge leaves the state alone.
            if (have_prev && !prev_cen) begin
                assert (window === prev_window) else begin
                    err_count++;
                    $display("mismatch at %0t: window expected %h actual %h",
                             $time, prev_window, window);
                end
                if (req == prev_req) begin
                    assert (rdy === prev_rdy) else begin
                        err_count++;
                        $display("mismatch at %0t: rdy expected %b actual %b",
                                 $time, prev_rdy, rdy);
                    end
                end
            end
            // refill latency bound.
            if (rdy) begin
                wait_cnt = 0;
            end else if (cen) begin
                wait_cnt++;
                assert (wait_cnt <= rdy_bound) else begin
                    err_count++;
                    $display("request at %0t waited more than %0d cen cycles for rdy",
                             $time, rdy_bound);
                    wait_cnt = 0;
                end
            end
            if (cen) seen_cen = 1'b1;
            prev_cen    = cen;
            prev_rdy    = rdy;
            prev_window = window;
            prev_req    = req;
            have_prev   = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verification/fetch_unit_tb.sv
`default_nettype none

module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam int clk_period = 8;
    localparam int reset_cycles = 4;
    localparam int num_requests = 200;
    localparam int refill_cycles = 16;
    localparam int hold_cycles = 2;
    // four clocks per cen cycle is a wide margin at 75% high.
    localparam int cen_stretch = 4;
    localparam int freeze_len = 5;
    localparam int freeze_every = 20;
    localparam int rdy_wait_limit = 64;
    localparam int preload_cycles = mem_words + 8;
    localparam int freeze_cycles = (num_requests / freeze_every) * (freeze_len + 1);
    localparam int watchdog_cycles = reset_cycles + preload_cycles + freeze_cycles +
                                     num_requests * (refill_cycles + hold_cycles) * cen_stretch;

    logic clk;
    logic rst;
    logic cen;
    fetch_req_t req;
    operand_req_t opreq;
    preload_t preload;
    logic [window_bits-1:0] operand;
    logic [window_bits-1:0] window;
    logic rdy;

    int check_errors;
    int stall_errors;
    logic [addr_bits-1:0] last_addr;

    fetch_unit UUT (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .req     (req),
        .opreq   (opreq),
        .preload (preload),
        .operand (operand),
        .window  (window),
        .rdy     (rdy)
    );

    // reference image and assertions.
    fetch_checks u_checks (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .req     (req),
        .opreq   (opreq),
        .preload (preload),
        .operand (operand),
        .window  (window),
        .rdy     (rdy),
        .errors  (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run timed out", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // 75% high.
    function automatic logic random_cen();
        return ($urandom % 4) != 0;
    endfunction

    // every word gets random data.
    task automatic preload_memory();
        for (int w = 0; w < mem_words; w++) begin
            @(negedge clk);
            preload.we   = 1'b1;
            preload.addr = 11'(w);
            preload.data = 16'($urandom);
        end
        @(negedge clk);
        preload.we = 1'b0;
    endtask

    // far jumps at even and odd addresses or short forward steps.
    task automatic make_request(output fetch_req_t r);
        int unsigned kind;
        logic [addr_bits-1:0] addr;
        logic [addr_bits-1:0] far;
        kind = $urandom % 5;
        if (kind == 0) addr = 24'($urandom) & ~24'h000001;
        else if (kind == 1) addr = 24'($urandom) | 24'h000001;
        else addr = last_addr + 24'(kind - 1);
        far = 24'h000800 + 24'($urandom % 1024);
        r.ldram_en = ($urandom % 4) == 0;
        if (r.ldram_en) begin
            // pc far from the data address.
            r.idx_addr = addr;
            r.pc       = addr + far;
        end else begin
            r.pc       = addr;
            r.idx_addr = 24'($urandom);
        end
        last_addr = addr;
    endtask

    // drive a request and wait for rdy.
    task automatic present_request(input fetch_req_t r, input logic freeze);
        int waited;
        logic got;
        @(negedge clk);
        req = r;
        if (freeze) begin
            // one cen edge starts the refill and then cen stalls.
            cen = 1'b1;
            @(negedge clk);
            cen = 1'b0;
            repeat (freeze_len - 1) @(negedge clk);
        end else begin
            cen = random_cen();
        end
        waited = 0;
        got    = 1'b0;
        while (!got && waited < rdy_wait_limit) begin
            @(posedge clk);
            if (rdy) begin
                got = 1'b1;
            end else begin
                waited++;
                @(negedge clk);
                cen = random_cen();
            end
        end
        if (!got) begin
            stall_errors++;
            $display("request pc %h idx %h ldram %b never raised rdy within %0d cycles",
                     r.pc, r.idx_addr, r.ldram_en, rdy_wait_limit);
        end
    endtask

    // walks all six size and sign pairs every three requests.
    task automatic hold_operands(input int i);
        int c;
        for (int j = 0; j < hold_cycles; j++) begin
            @(negedge clk);
            c = (2 * i + j) % 6;
            opreq.size = op_size_t'(2'(c % 3));
            opreq.sign = (c / 3) != 0;
            cen = random_cen();
        end
    endtask

    initial begin
        fetch_req_t r;
        void'($urandom(32'hf7c0418a));
        rst = 1'b1;
        cen = 1'b0;
        req = '0;
        opreq = '0;
        preload = '0;
        stall_errors = 0;
        last_addr = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // cen stays low until the image is loaded.
        preload_memory();
        for (int i = 0; i < num_requests; i++) begin
            make_request(r);
            present_request(r, (i % freeze_every) == (freeze_every / 2));
            hold_operands(i);
        end
        @(negedge clk);
        cen = 1'b0;
        repeat (2) @(posedge clk);
        // checker counts settle before the report.
        @(negedge clk);
        $display("closing report: checker errors %0d, stimulus errors %0d",
                 check_errors, stall_errors);
        if (check_errors == 0 && stall_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
